/* Makefile */
# Verilator build and run for the memory stage testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_stage
FILELIST  ?= mem_stage.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* load_align.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_stage_config.svh"

module load_align (
    input  mem_pkg::mem_op_e        op,
    input  logic [1:0]              addr_low,
    input  logic [`MEM_XLEN-1:0]    read_data,
    input  logic                    data_ok,
    input  logic                    lane_valid,
    input  logic [`MEM_XLEN-1:0]    reg_write_data,
    output logic [`MEM_XLEN-1:0]    result,
    output logic                    load_pending
);

    import mem_pkg::*;

    logic                   is_load;
    logic [`MEM_BYTE_W-1:0] byte_sel;
    logic [`MEM_HALF_W-1:0] half_sel;
    logic [`MEM_XLEN-1:0]   byte_sext;
    logic [`MEM_XLEN-1:0]   byte_zext;
    logic [`MEM_XLEN-1:0]   half_sext;
    logic [`MEM_XLEN-1:0]   half_zext;

    assign is_load = is_load_op(op);

    // byte lane picked by the low address bits
    always_comb begin
        case (addr_low)
            2'd0:    byte_sel = read_data[7:0];
            2'd1:    byte_sel = read_data[15:8];
            2'd2:    byte_sel = read_data[23:16];
            default: byte_sel = read_data[31:24];
        endcase
    end

    // halfword only on a 2-byte boundary
    always_comb begin
        case (addr_low)
            2'd0:    half_sel = read_data[15:0];
            2'd2:    half_sel = read_data[31:16];
            default: half_sel = '0;   // misaligned, no exception raised here
        endcase
    end

    assign byte_sext = {{(`MEM_XLEN - `MEM_BYTE_W){byte_sel[`MEM_BYTE_W-1]}}, byte_sel};
    assign byte_zext = {{(`MEM_XLEN - `MEM_BYTE_W){1'b0}}, byte_sel};
    assign half_sext = {{(`MEM_XLEN - `MEM_HALF_W){half_sel[`MEM_HALF_W-1]}}, half_sel};
    assign half_zext = {{(`MEM_XLEN - `MEM_HALF_W){1'b0}}, half_sel};

    always_comb begin
        result = reg_write_data;   // non-loads pass through
        if (is_load) begin
            if (!data_ok) begin
                result = '0;
            end else begin
                case (op)
                    op_ld_b:  result = byte_sext;
                    op_ld_bu: result = byte_zext;
                    op_ld_h:  result = half_sext;
                    op_ld_hu: result = half_zext;
                    default:  result = read_data;   // ld.w, ll.w
                endcase
            end
        end
    end

    // waiting on the data cache
    assign load_pending = lane_valid & is_load & ~data_ok;

endmodule

`default_nettype wire

/* mem_stage.f */
+incdir+.
mem_stage_pkg.sv
load_align.sv
mem_stage.sv
mem_stage_monitor.sv
mem_stage_chk.sv
tb_mem_stage.sv

/* mem_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_stage_config.svh"

module mem_stage (
    input  mem_pkg::mem_lane_t  [`MEM_ISSUE_W-1:0] lanes,
    input  logic                [`MEM_XLEN-1:0]    dcache_read_data,
    input  logic                                   data_ok,
    output mem_pkg::reg_write_t [`MEM_ISSUE_W-1:0] pf_write,
    output mem_pkg::reg_write_t [`MEM_ISSUE_W-1:0] wb_write,
    output mem_pkg::commit_t    [`MEM_ISSUE_W-1:0] commit,
    output logic                                   pause_mem
);

    import mem_pkg::*;

    reg_write_t [`MEM_ISSUE_W-1:0]              lane_write;
    logic       [`MEM_ISSUE_W-1:0][`MEM_XLEN-1:0] lane_result;
    logic       [`MEM_ISSUE_W-1:0]              lane_pending;
    logic       [`MEM_ISSUE_W-1:0]              lane_exc;
    logic                                       any_exc;

    // lane 0 load path
    load_align u_lane0 (
        .op             (lanes[0].op),
        .addr_low       (lanes[0].mem_addr[1:0]),
        .read_data      (dcache_read_data),
        .data_ok        (data_ok),
        .lane_valid     (lanes[0].valid),
        .reg_write_data (lanes[0].reg_write_data),
        .result         (lane_result[0]),
        .load_pending   (lane_pending[0])
    );

    // lane 1 shares the same cache read word
    load_align u_lane1 (
        .op             (lanes[1].op),
        .addr_low       (lanes[1].mem_addr[1:0]),
        .read_data      (dcache_read_data),
        .data_ok        (data_ok),
        .lane_valid     (lanes[1].valid),
        .reg_write_data (lanes[1].reg_write_data),
        .result         (lane_result[1]),
        .load_pending   (lane_pending[1])
    );

    // register write as it arrived from execute
    always_comb begin
        for (int i = 0; i < `MEM_ISSUE_W; i++) begin
            lane_write[i].en   = lanes[i].reg_write_en;
            lane_write[i].addr = lanes[i].reg_write_addr;
            lane_write[i].data = lanes[i].reg_write_data;
        end
    end

    // forwarding sees the unaligned value, writeback the loaded one
    always_comb begin
        for (int i = 0; i < `MEM_ISSUE_W; i++) begin
            pf_write[i]      = lane_write[i];
            wb_write[i].en   = lane_write[i].en;
            wb_write[i].addr = lane_write[i].addr;
            wb_write[i].data = lane_result[i];
        end
    end

    always_comb begin
        for (int i = 0; i < `MEM_ISSUE_W; i++) begin
            commit[i].valid     = lanes[i].valid;
            commit[i].pc        = lanes[i].pc;
            commit[i].addr      = lanes[i].mem_addr;
            commit[i].exc_flags = {lanes[i].exc_flags, 1'b0};   // mem stage adds no fault
        end
    end

    // any flag in either lane, valid or not
    always_comb begin
        for (int i = 0; i < `MEM_ISSUE_W; i++) begin
            lane_exc[i] = |lanes[i].exc_flags;
        end
    end

    assign any_exc = |lane_exc;

    // a faulting lane flushes, so no point stalling for data
    assign pause_mem = (|lane_pending) & ~any_exc;

endmodule

`default_nettype wire

/* mem_stage_chk.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_stage_config.svh"

module mem_stage_chk (
    input logic                                   clk,
    input logic                                   rst_n,
    input mem_pkg::mem_lane_t  [`MEM_ISSUE_W-1:0] lanes,
    input logic                                   data_ok,
    input mem_pkg::reg_write_t [`MEM_ISSUE_W-1:0] wb_write,
    input logic                                   pause_mem
);

    import mem_pkg::*;

    int   fail_pause_exc = 0;
    int   fail_pause_ok = 0;
    int   fail_pass0 = 0;
    int   fail_pass1 = 0;
    int   fail_count;
    logic any_flag;

    assign any_flag = (|lanes[0].exc_flags) | (|lanes[1].exc_flags);
    assign fail_count = fail_pause_exc + fail_pause_ok + fail_pass0 + fail_pass1;

    // a faulting lane never stalls the pipe
    no_pause_on_exc: assert property (@(posedge clk) disable iff (!rst_n)
        any_flag |-> !pause_mem)
        else begin
            fail_pause_exc++;
            $error("pause_mem high while an exception flag is set");
        end

    no_pause_with_data: assert property (@(posedge clk) disable iff (!rst_n)
        data_ok |-> !pause_mem)
        else begin
            fail_pause_ok++;
            $error("pause_mem high while data_ok is high");
        end

    lane0_passes_data: assert property (@(posedge clk) disable iff (!rst_n)
        (lanes[0].valid && lanes[0].op == op_other) |->
        wb_write[0].data == lanes[0].reg_write_data)
        else begin
            fail_pass0++;
            $error("lane 0 non-load result differs from its register data");
        end

    lane1_passes_data: assert property (@(posedge clk) disable iff (!rst_n)
        (lanes[1].valid && lanes[1].op == op_other) |->
        wb_write[1].data == lanes[1].reg_write_data)
        else begin
            fail_pass1++;
            $error("lane 1 non-load result differs from its register data");
        end

endmodule

`default_nettype wire

/* mem_stage_config.svh */
`ifndef MEM_STAGE_CONFIG_SVH
`define MEM_STAGE_CONFIG_SVH

// datapath widths
`define MEM_XLEN            32
`define MEM_BYTE_W          8
`define MEM_HALF_W          16

// register file index
`define MEM_REG_ADDR_W      5

// opcode field carried from execute
`define MEM_OP_W            8

// two issue lanes
`define MEM_ISSUE_W         2

// exception flag vector from execute
`define MEM_EXC_W           5

// commit adds one memory-stage flag below the incoming ones
`define MEM_COMMIT_EXC_W    (`MEM_EXC_W + 1)

`endif

/* mem_stage_monitor.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_stage_config.svh"

module mem_stage_monitor (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   check_en,
    input  logic                                   report,
    input  mem_pkg::mem_lane_t  [`MEM_ISSUE_W-1:0] lanes,
    input  logic [`MEM_ISSUE_W-1:0][`MEM_XLEN-1:0] exp_wb,
    input  logic                                   exp_pause,
    input  mem_pkg::reg_write_t [`MEM_ISSUE_W-1:0] pf_write,
    input  mem_pkg::reg_write_t [`MEM_ISSUE_W-1:0] wb_write,
    input  mem_pkg::commit_t    [`MEM_ISSUE_W-1:0] commit,
    input  logic                                   pause_mem,
    input  int                                     timeouts,
    input  int                                     assert_fails,
    output int                                     error_count
);

    import mem_pkg::*;

    int check_count;

    initial begin
        error_count = 0;
        check_count = 0;
    end

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
        end
    endtask

    task automatic check_lane(input int i);
        logic [`MEM_COMMIT_EXC_W-1:0] exp_flags;
        exp_flags = '0;
        exp_flags[`MEM_COMMIT_EXC_W-1:1] = lanes[i].exc_flags;   // bit 0 is the mem stage's own
        compare($sformatf("pf_write[%0d].en", i), 64'(lanes[i].reg_write_en),
                64'(pf_write[i].en));
        compare($sformatf("pf_write[%0d].addr", i), 64'(lanes[i].reg_write_addr),
                64'(pf_write[i].addr));
        compare($sformatf("pf_write[%0d].data", i), 64'(lanes[i].reg_write_data),
                64'(pf_write[i].data));
        compare($sformatf("wb_write[%0d].en", i), 64'(lanes[i].reg_write_en),
                64'(wb_write[i].en));
        compare($sformatf("wb_write[%0d].addr", i), 64'(lanes[i].reg_write_addr),
                64'(wb_write[i].addr));
        compare($sformatf("wb_write[%0d].data", i), 64'(exp_wb[i]), 64'(wb_write[i].data));
        compare($sformatf("commit[%0d].valid", i), 64'(lanes[i].valid), 64'(commit[i].valid));
        compare($sformatf("commit[%0d].pc", i), 64'(lanes[i].pc), 64'(commit[i].pc));
        compare($sformatf("commit[%0d].addr", i), 64'(lanes[i].mem_addr), 64'(commit[i].addr));
        compare($sformatf("commit[%0d].exc_flags", i), 64'(exp_flags),
                64'(commit[i].exc_flags));
    endtask

    // sampled on the edge, inputs move 1 ns later
    always @(posedge clk) begin
        if (!rst_n) begin
            compare("pause_mem", 64'd0, 64'(pause_mem));
            for (int i = 0; i < `MEM_ISSUE_W; i++) begin
                compare($sformatf("commit[%0d].valid", i), 64'd0, 64'(commit[i].valid));
                compare($sformatf("pf_write[%0d].en", i), 64'd0, 64'(pf_write[i].en));
                compare($sformatf("wb_write[%0d].en", i), 64'd0, 64'(wb_write[i].en));
            end
        end else if (check_en) begin
            compare("pause_mem", 64'(exp_pause), 64'(pause_mem));
            for (int i = 0; i < `MEM_ISSUE_W; i++) begin
                check_lane(i);
            end
        end
    end

    always @(posedge report) begin
        $display("checks %0d, value errors %0d, assertion failures %0d, timeouts %0d",
                 check_count, error_count, assert_fails, timeouts);
    end

endmodule

`default_nettype wire

/* mem_stage_pkg.sv */
`default_nettype none

`include "mem_stage_config.svh"

package mem_pkg;

    // load opcodes seen by the memory stage
    typedef enum logic [`MEM_OP_W-1:0] {
        op_none  = 8'h00,
        op_ld_b  = 8'h20,
        op_ld_bu = 8'h21,
        op_ld_h  = 8'h22,
        op_ld_hu = 8'h23,
        op_ld_w  = 8'h24,
        op_ll_w  = 8'h25,
        op_other = 8'hff   // any non-load
    } mem_op_e;

    // one lane leaving execute
    typedef struct packed {
        logic                       valid;
        logic [`MEM_XLEN-1:0]       pc;
        mem_op_e                    op;
        logic [`MEM_XLEN-1:0]       mem_addr;
        logic                       reg_write_en;
        logic [`MEM_REG_ADDR_W-1:0] reg_write_addr;
        logic [`MEM_XLEN-1:0]       reg_write_data;
        logic [`MEM_EXC_W-1:0]      exc_flags;
    } mem_lane_t;

    // register write toward forwarding and writeback
    typedef struct packed {
        logic                       en;
        logic [`MEM_REG_ADDR_W-1:0] addr;
        logic [`MEM_XLEN-1:0]       data;
    } reg_write_t;

    // one lane toward commit control
    typedef struct packed {
        logic                         valid;
        logic [`MEM_XLEN-1:0]         pc;
        logic [`MEM_XLEN-1:0]         addr;
        logic [`MEM_COMMIT_EXC_W-1:0] exc_flags;
    } commit_t;

    function automatic logic is_load_op(input mem_op_e op);
        logic hit;
        case (op)
            op_ld_b,
            op_ld_bu,
            op_ld_h,
            op_ld_hu,
            op_ld_w,
            op_ll_w: hit = 1'b1;
            default: hit = 1'b0;
        endcase
        return hit;
    endfunction

endpackage

`default_nettype wire

/* tb_mem_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_stage_config.svh"

module tb_mem_stage;

    import mem_pkg::*;

    typedef struct packed {
        mem_lane_t [`MEM_ISSUE_W-1:0]           lanes;
        logic [`MEM_XLEN-1:0]                   rdata;
        logic                                   data_ok;
        logic [`MEM_ISSUE_W-1:0][`MEM_XLEN-1:0] exp_wb;
        logic                                   exp_pause;
    } entry_t;

    localparam int CLK_HALF       = 4;
    localparam int RESET_CYCLES   = 10;
    localparam int RESET_WAIT_MAX = 40;

    logic                                   clk;
    logic                                   rst_n;
    mem_lane_t  [`MEM_ISSUE_W-1:0]          lanes;
    logic [`MEM_XLEN-1:0]                   dcache_read_data;
    logic                                   data_ok;
    reg_write_t [`MEM_ISSUE_W-1:0]          pf_write;
    reg_write_t [`MEM_ISSUE_W-1:0]          wb_write;
    commit_t    [`MEM_ISSUE_W-1:0]          commit;
    logic                                   pause_mem;

    logic                                   check_en;
    logic [`MEM_ISSUE_W-1:0][`MEM_XLEN-1:0] exp_wb;
    logic                                   exp_pause;
    logic                                   report;
    int                                     timeouts;
    int                                     error_count;
    int                                     assert_fails;

    logic [`MEM_XLEN-1:0]                   cur_word;   // cache word for the entries being built
    logic                                   cur_ok;
    entry_t                                 table_q[$];

    mem_stage uut (
        .lanes            (lanes),
        .dcache_read_data (dcache_read_data),
        .data_ok          (data_ok),
        .pf_write         (pf_write),
        .wb_write         (wb_write),
        .commit           (commit),
        .pause_mem        (pause_mem)
    );

    mem_stage_monitor u_monitor (
        .clk          (clk),
        .rst_n        (rst_n),
        .check_en     (check_en),
        .report       (report),
        .lanes        (lanes),
        .exp_wb       (exp_wb),
        .exp_pause    (exp_pause),
        .pf_write     (pf_write),
        .wb_write     (wb_write),
        .commit       (commit),
        .pause_mem    (pause_mem),
        .timeouts     (timeouts),
        .assert_fails (assert_fails),
        .error_count  (error_count)
    );

    bind mem_stage mem_stage_chk u_chk (
        .clk       (tb_mem_stage.clk),
        .rst_n     (tb_mem_stage.rst_n),
        .lanes     (lanes),
        .data_ok   (data_ok),
        .wb_write  (wb_write),
        .pause_mem (pause_mem)
    );

    assign assert_fails = uut.u_chk.fail_count;

    function automatic mem_lane_t make_lane(input logic valid, input mem_op_e op,
                                            input logic [1:0] off,
                                            input logic [`MEM_XLEN-1:0] rwd,
                                            input logic [`MEM_EXC_W-1:0] exc);
        mem_lane_t            l;
        logic [`MEM_XLEN-1:0] r;
        l = '0;
        r = $urandom;
        l.pc = {r[`MEM_XLEN-1:2], 2'b00};
        r = $urandom;
        l.mem_addr = {r[`MEM_XLEN-1:2], off};   // upper address bits are don't-care
        r = $urandom;
        l.reg_write_addr = r[`MEM_REG_ADDR_W-1:0];
        l.valid = valid;
        l.op = op;
        l.reg_write_en = valid & r[`MEM_REG_ADDR_W];
        l.reg_write_data = rwd;
        l.exc_flags = exc;
        return l;
    endfunction

    // valid load, data field unused
    function automatic mem_lane_t ld(input mem_op_e op, input logic [1:0] off);
        return make_lane(1'b1, op, off, $urandom, '0);
    endfunction

    function automatic mem_lane_t alu(input mem_op_e op, input logic [`MEM_XLEN-1:0] rwd);
        return make_lane(1'b1, op, 2'd0, rwd, '0);
    endfunction

    function automatic void push_entry(input mem_lane_t l0, input mem_lane_t l1,
                                       input logic [`MEM_XLEN-1:0] wb0,
                                       input logic [`MEM_XLEN-1:0] wb1,
                                       input logic pause);
        entry_t e;
        e.lanes[0] = l0;
        e.lanes[1] = l1;
        e.rdata = cur_word;
        e.data_ok = cur_ok;
        e.exp_wb[0] = wb0;
        e.exp_wb[1] = wb1;
        e.exp_pause = pause;
        table_q.push_back(e);
    endfunction

    task automatic fill_table();
        mem_lane_t l0;
        mem_lane_t l1;
        cur_ok = 1'b1;
        cur_word = 32'h7f8015e2;   // byte signs -, +, -, + from offset 0
        push_entry(ld(op_ld_b, 2'd0), ld(op_ld_bu, 2'd0), 32'hffffffe2, 32'h000000e2, 1'b0);
        push_entry(ld(op_ld_b, 2'd1), ld(op_ld_bu, 2'd1), 32'h00000015, 32'h00000015, 1'b0);
        push_entry(ld(op_ld_b, 2'd2), ld(op_ld_bu, 2'd2), 32'hffffff80, 32'h00000080, 1'b0);
        push_entry(ld(op_ld_b, 2'd3), ld(op_ld_bu, 2'd3), 32'h0000007f, 32'h0000007f, 1'b0);
        cur_word = 32'h8c3fa761;   // opposite signs
        push_entry(ld(op_ld_bu, 2'd0), ld(op_ld_b, 2'd0), 32'h00000061, 32'h00000061, 1'b0);
        push_entry(ld(op_ld_bu, 2'd1), ld(op_ld_b, 2'd1), 32'h000000a7, 32'hffffffa7, 1'b0);
        push_entry(ld(op_ld_bu, 2'd2), ld(op_ld_b, 2'd2), 32'h0000003f, 32'h0000003f, 1'b0);
        push_entry(ld(op_ld_bu, 2'd3), ld(op_ld_b, 2'd3), 32'h0000008c, 32'hffffff8c, 1'b0);
        cur_word = 32'h9a3c7e01;
        push_entry(ld(op_ld_h, 2'd0), ld(op_ld_hu, 2'd2), 32'h00007e01, 32'h00009a3c, 1'b0);
        push_entry(ld(op_ld_hu, 2'd0), ld(op_ld_h, 2'd2), 32'h00007e01, 32'hffff9a3c, 1'b0);
        push_entry(ld(op_ld_h, 2'd1), ld(op_ld_hu, 2'd3), 32'h00000000, 32'h00000000, 1'b0);
        cur_word = 32'h1234f00d;
        push_entry(ld(op_ld_h, 2'd0), ld(op_ld_hu, 2'd0), 32'hfffff00d, 32'h0000f00d, 1'b0);
        push_entry(ld(op_ld_h, 2'd2), ld(op_ld_hu, 2'd2), 32'h00001234, 32'h00001234, 1'b0);
        push_entry(ld(op_ld_hu, 2'd1), ld(op_ld_h, 2'd3), 32'h00000000, 32'h00000000, 1'b0);
        cur_word = 32'hdeadbeef;
        push_entry(ld(op_ld_w, 2'd0), ld(op_ll_w, 2'd0), 32'hdeadbeef, 32'hdeadbeef, 1'b0);
        // mixed load and non-load lanes
        cur_word = 32'h0badf00d;
        l0 = alu(op_other, 32'h13572468);
        push_entry(l0, ld(op_ld_w, 2'd0), 32'h13572468, 32'h0badf00d, 1'b0);
        cur_word = 32'h0000ab00;
        l1 = alu(op_other, 32'hcafebabe);
        push_entry(ld(op_ld_bu, 2'd1), l1, 32'h000000ab, 32'hcafebabe, 1'b0);
        l0 = alu(op_none, 32'h00c0ffee);
        push_entry(l0, alu(op_other, 32'h80000001), 32'h00c0ffee, 32'h80000001, 1'b0);
        // stall, then data arrives with the same lanes held
        cur_word = 32'h5555aaaa;
        cur_ok = 1'b0;
        l0 = ld(op_ld_w, 2'd0);
        l1 = alu(op_other, 32'h24681357);
        push_entry(l0, l1, 32'h00000000, 32'h24681357, 1'b1);
        cur_ok = 1'b1;
        push_entry(l0, l1, 32'h5555aaaa, 32'h24681357, 1'b0);
        cur_ok = 1'b0;
        push_entry(ld(op_ld_h, 2'd2), ld(op_ld_b, 2'd1), 32'h00000000, 32'h00000000, 1'b1);
        l0 = make_lane(1'b0, op_ld_w, 2'd0, $urandom, '0);   // invalid load must not stall
        push_entry(l0, alu(op_other, 32'h0f0f0f0f), 32'h00000000, 32'h0f0f0f0f, 1'b0);
        l1 = make_lane(1'b0, op_ld_hu, 2'd2, $urandom, '0);   // same for lane 1
        push_entry(alu(op_other, 32'h5a5a5a5a), l1, 32'h5a5a5a5a, 32'h00000000, 1'b0);
        l0 = alu(op_none, 32'h0000beef);   // lane 1 alone stalls
        push_entry(l0, ld(op_ld_b, 2'd3), 32'h0000beef, 32'h00000000, 1'b1);
        // exception flags suppress the stall
        l0 = make_lane(1'b1, op_ld_b, 2'd0, $urandom, 5'b00100);
        push_entry(l0, alu(op_other, 32'h11112222), 32'h00000000, 32'h11112222, 1'b0);
        l1 = make_lane(1'b1, op_other, 2'd0, 32'h33334444, 5'b10001);
        push_entry(ld(op_ld_w, 2'd0), l1, 32'h00000000, 32'h33334444, 1'b0);
        l1 = make_lane(1'b0, op_none, 2'd0, 32'h77778888, 5'b01000);
        push_entry(ld(op_ld_hu, 2'd0), l1, 32'h00000000, 32'h77778888, 1'b0);
        cur_ok = 1'b1;
        cur_word = 32'h89abcdef;
        l0 = make_lane(1'b1, op_ld_w, 2'd0, $urandom, 5'b11111);
        push_entry(l0, ld(op_ld_bu, 2'd3), 32'h89abcdef, 32'h00000089, 1'b0);
    endtask

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

    initial begin
        int waited;
        void'($urandom(32'hc2c9));
        lanes = '0;   // both lanes invalid through reset
        dcache_read_data = '0;
        data_ok = 1'b0;
        check_en = 1'b0;
        exp_wb = '0;
        exp_pause = 1'b0;
        report = 1'b0;
        timeouts = 0;
        cur_word = '0;
        cur_ok = 1'b0;
        fill_table();
        waited = 0;
        while (rst_n !== 1'b1 && waited < RESET_WAIT_MAX) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            timeouts++;
            $display("reset was not released within %0d cycles", RESET_WAIT_MAX);
        end else begin
            foreach (table_q[i]) begin
                #1;
                lanes = table_q[i].lanes;
                dcache_read_data = table_q[i].rdata;
                data_ok = table_q[i].data_ok;
                exp_wb = table_q[i].exp_wb;
                exp_pause = table_q[i].exp_pause;
                check_en = 1'b1;
                @(posedge clk);   // monitor compares on this edge
            end
            #1;
            check_en = 1'b0;
        end
        report = 1'b1;
        #1;
        if (error_count == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
